// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_tile_profiler
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= src.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  := Test failures found

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for failures"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	@./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation FAILED"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/tb_clk_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen
  (
   output logic clk,
   output logic rst_n_o
   );

   localparam int half_period_lp = 4;  // 8 ns clock

   initial
   begin
      clk     = 1'b0;
      rst_n_o = 1'b0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst_n_o = 1'b1;  // released on a falling edge
   end

   always #half_period_lp clk = ~clk;

endmodule

`default_nettype wire

// ==== dv/tb_tile_profiler.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_tile_profiler;

   localparam int clk_period_lp  = 8;
   localparam int num_windows_lp = 12;
   localparam int max_win_len_lp = 40;
   localparam int burst_len_lp   = 100;
   // reset reads, windows with gaps, read burst, then slack
   localparam int max_cycles_lp  = 40 + num_windows_lp * (max_win_len_lp + 24)
                                   + burst_len_lp + 200;

   logic                                     clk;
   logic                                     rst_n_i;
   logic [prof_pkg::coord_width_lp-1:0]      tile_x_i;
   logic [prof_pkg::coord_width_lp-1:0]      tile_y_i;
   logic                                     freeze_i;
   logic                                     finish_i;
   logic                                     dmem_stall_i;
   logic                                     dx_stall_i;
   logic                                     bt_stall_i;
   logic                                     res_acq_stall_i;
   logic                                     in_ready_i;
   logic                                     out_ready_i;
   logic [prof_pkg::credit_width_lp-1:0]     out_credits_i;
   logic                                     rd_en_i;
   logic [prof_pkg::idx_width_lp-1:0]        rd_idx_i;
   logic [prof_pkg::cnt_width_lp-1:0]        rd_data_o;
   logic                                     rd_valid_o;

   // reference model state, as it stands after the last rising edge
   logic                                     m_freeze_r;
   logic                                     m_active;
   logic                                     m_done;
   logic [prof_pkg::win_cnt_width_lp-1:0]    m_win_count;
   logic [prof_pkg::cnt_width_lp-1:0]        m_cycles;
   logic [prof_pkg::cnt_width_lp-1:0]        m_cnt [7];  // dmem .. credit

   logic [prof_pkg::cnt_width_lp-1:0]        exp_q [$];
   logic                                     exp_pend;   // response due now
   integer                                   seed;
   int                                       errors;
   int                                       checks;

   tb_clk_gen clk_gen_i (.clk(clk), .rst_n_o(rst_n_i));

   tile_profiler dut_i
     (.clk              (clk)
      ,.rst_n_i          (rst_n_i)
      ,.tile_x_i         (tile_x_i)
      ,.tile_y_i         (tile_y_i)
      ,.freeze_i         (freeze_i)
      ,.finish_i         (finish_i)
      ,.dmem_stall_i     (dmem_stall_i)
      ,.dx_stall_i       (dx_stall_i)
      ,.bt_stall_i       (bt_stall_i)
      ,.res_acq_stall_i  (res_acq_stall_i)
      ,.in_ready_i       (in_ready_i)
      ,.out_ready_i      (out_ready_i)
      ,.out_credits_i    (out_credits_i)
      ,.rd_en_i          (rd_en_i)
      ,.rd_idx_i         (rd_idx_i)
      ,.rd_data_o        (rd_data_o)
      ,.rd_valid_o       (rd_valid_o)
      );

   //////////////////////////////
   // reference model
   //////////////////////////////

   function automatic int rand_between(input int lo, input int hi);
      rand_between = lo + (($random(seed) & 32'h7fff_ffff) % (hi - lo + 1));
   endfunction

   function automatic logic [prof_pkg::cnt_width_lp-1:0] sat_inc
     (input logic [prof_pkg::cnt_width_lp-1:0] v);
      sat_inc = (v == '1) ? v : v + 1;
   endfunction

   function automatic logic [prof_pkg::cnt_width_lp-1:0] model_word
     (input logic [prof_pkg::idx_width_lp-1:0] idx);
      prof_pkg::prof_rd_word_u w;
      w.raw = '0;
      if (idx == prof_pkg::idx_status_lp)
      begin
         w.status.tile_y    = tile_y_i;
         w.status.tile_x    = tile_x_i;
         w.status.active    = m_active;
         w.status.done      = m_done;
         w.status.win_count = m_win_count;
      end
      else if (idx == prof_pkg::idx_cycles_lp)
         w.raw = m_cycles;
      else if (idx <= prof_pkg::idx_credit_lp)
         w.raw = m_cnt[idx - prof_pkg::idx_dmem_lp];
      model_word = w.raw;  // 9..15 stay zero
   endfunction

   // one rising edge, using the inputs that edge sampled
   task automatic model_step();
      logic       unfreeze;
      logic [6:0] ev;
      unfreeze = m_freeze_r & ~freeze_i;
      ev = {(out_credits_i == '0), ~out_ready_i, ~in_ready_i,
            res_acq_stall_i, bt_stall_i, dx_stall_i, dmem_stall_i};
      if (unfreeze)
      begin
         m_cycles = '0;
         for (int i = 0; i < 7; i++)
            m_cnt[i] = '0;
         m_active = 1'b1;
         m_done   = 1'b0;
      end
      else if (m_active)
      begin
         m_cycles = sat_inc(m_cycles);
         for (int i = 0; i < 7; i++)
         begin
            if (ev[i])
               m_cnt[i] = sat_inc(m_cnt[i]);
         end
         if (finish_i)
         begin
            m_active = 1'b0;
            m_done   = 1'b1;
            if (m_win_count != '1)
               m_win_count = m_win_count + 1'b1;
         end
      end
      m_freeze_r = freeze_i;
   endtask

   task automatic check_response();
      logic [prof_pkg::cnt_width_lp-1:0] exp;
      assert (rd_valid_o === exp_pend)
      else
      begin
         errors++;
         $display("[FAIL] rd_valid_o expected %h got %h", exp_pend, rd_valid_o);
      end
      if (exp_pend)
      begin
         exp = exp_q.pop_front();
         checks++;
         assert (rd_data_o === exp)
         else
         begin
            errors++;
            $display("[FAIL] rd_data_o expected %h got %h", exp, rd_data_o);
         end
      end
   endtask

   //////////////////////////////
   // stimulus
   //////////////////////////////

   // check, advance the model, then drive the next cycle's inputs
   task automatic tick(input logic fz, input logic fin, input logic rd,
                       input logic [prof_pkg::idx_width_lp-1:0] idx);
      @(negedge clk);
      check_response();
      model_step();
      exp_pend = rd_en_i;
      if (rd_en_i)
         exp_q.push_back(model_word(rd_idx_i));
      freeze_i        = fz;
      finish_i        = fin;
      rd_en_i         = rd;
      rd_idx_i        = idx;
      dmem_stall_i    = rand_between(0, 1) != 0;
      dx_stall_i      = rand_between(0, 1) != 0;
      bt_stall_i      = rand_between(0, 3) == 0;
      res_acq_stall_i = rand_between(0, 3) == 0;
      in_ready_i      = rand_between(0, 2) != 0;  // mostly ready
      out_ready_i     = rand_between(0, 2) != 0;
      out_credits_i   = (rand_between(0, 2) == 0) ? '0 : 4'(rand_between(0, 15));
   endtask

   task automatic random_tick(input logic fz, input logic fin);
      tick(fz, fin, rand_between(0, 3) != 0, 4'(rand_between(0, 15)));
   endtask

   task automatic run_window(input bit restart);
      int fz_len;
      int win_len;
      int gap_len;
      int cut;
      fz_len  = rand_between(1, 3);
      win_len = rand_between(4, max_win_len_lp);
      gap_len = rand_between(2, 10);
      cut     = rand_between(1, win_len - 1);
      repeat (fz_len) random_tick(1'b1, rand_between(0, 3) == 0);
      for (int i = 0; i < win_len; i++)
      begin
         if (restart && (i == cut))
         begin
            random_tick(1'b1, 1'b0);
            random_tick(1'b0, 1'b1);  // unfreeze and finish together
         end
         random_tick(1'b0, 1'b0);
      end
      random_tick(1'b0, 1'b1);
      // closed window, stray finishes ignored
      repeat (gap_len) random_tick(1'b0, rand_between(0, 3) == 0);
   endtask

   initial
   begin
      seed     = 2;
      errors   = 0;
      checks   = 0;
      exp_pend = 1'b0;
      m_freeze_r  = 1'b1;
      m_active    = 1'b0;
      m_done      = 1'b0;
      m_win_count = '0;
      m_cycles    = '0;
      for (int i = 0; i < 7; i++)
         m_cnt[i] = '0;
      tile_x_i        = 6'(rand_between(0, 63));
      tile_y_i        = 6'(rand_between(0, 63));
      freeze_i        = 1'b1;
      finish_i        = 1'b0;
      dmem_stall_i    = 1'b0;
      dx_stall_i      = 1'b0;
      bt_stall_i      = 1'b0;
      res_acq_stall_i = 1'b0;
      in_ready_i      = 1'b1;
      out_ready_i     = 1'b1;
      out_credits_i   = 4'd8;
      rd_en_i         = 1'b0;
      rd_idx_i        = '0;
      wait (rst_n_i === 1'b1);

      for (int i = 0; i < 16; i++)
         tick(1'b1, 1'b0, 1'b1, 4'(i));  // reset values, every index
      for (int w = 0; w < num_windows_lp; w++)
         run_window((w % 3) == 1);

      // back to back reads in one long window
      random_tick(1'b1, 1'b0);
      for (int i = 0; i < burst_len_lp; i++)
         tick(1'b0, 1'b0, 1'b1, 4'(rand_between(0, 15)));
      tick(1'b0, 1'b1, 1'b1, prof_pkg::idx_status_lp);
      repeat (3) tick(1'b0, 1'b0, 1'b0, '0);  // drain

      $display("errors: %0d, reads checked: %0d", errors, checks);
      if (errors == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

   // watchdog
   initial
   begin
      #(max_cycles_lp * clk_period_lp);
      $display("timeout: run did not end within %0d cycles", max_cycles_lp);
      $display("Test failures found");
      $finish;
   end

endmodule

`default_nettype wire

// ==== dv/tile_profiler_properties.sv ====
`timescale 1ns/1ns
`default_nettype none

module tile_profiler_properties
  (
   input wire                                clk,
   input wire                                rst_n_i,
   input wire                                rd_en_i,
   input wire                                rd_valid_i,
   input wire [prof_pkg::cnt_width_lp-1:0]   rd_data_i
   );

   //////////////////////////////
   // read port
   //////////////////////////////

   // response shows up two edges after the request is sampled
   no_req_no_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
                                     !rd_en_i |=> ##1 !rd_valid_i)
      else $error("rd_valid_o high without a read request");

   valid_low_in_reset: assert property (@(posedge clk) !rst_n_i |-> !rd_valid_i)
      else $error("rd_valid_o high while in reset");

   // returned word fully driven
   data_known: assert property (@(posedge clk) disable iff (!rst_n_i)
                                rd_valid_i |-> !$isunknown(rd_data_i))
      else $error("rd_data_o has unknown bits while valid");

endmodule

bind tile_profiler tile_profiler_properties props_i
  (.clk         (clk)
   ,.rst_n_i     (rst_n_i)
   ,.rd_en_i     (rd_en_i)
   ,.rd_valid_i  (rd_valid_o)
   ,.rd_data_i   (rd_data_o)
   );

`default_nettype wire

// ==== rtl/prof_core_stalls.sv ====
`timescale 1ns/1ns
`default_nettype none

module prof_core_stalls
  (
   input  wire                                clk,
   input  wire                                rst_n_i,
   input  wire                                clear_i,
   input  wire                                active_i,
   input  wire                                dmem_stall_i,
   input  wire                                dx_stall_i,
   input  wire                                bt_stall_i,
   input  wire                                res_acq_stall_i,
   output logic [prof_pkg::cnt_width_lp-1:0]  dmem_cnt_o,
   output logic [prof_pkg::cnt_width_lp-1:0]  dx_cnt_o,
   output logic [prof_pkg::cnt_width_lp-1:0]  bt_cnt_o,
   output logic [prof_pkg::cnt_width_lp-1:0]  res_acq_cnt_o
   );

   logic [prof_pkg::num_core_stalls_lp-1:0]                               stall_v;
   logic [prof_pkg::num_core_stalls_lp-1:0][prof_pkg::cnt_width_lp-1:0]   cnt_r;

   // bit order matches cnt_r slots below
   assign stall_v = {res_acq_stall_i, bt_stall_i, dx_stall_i, dmem_stall_i};

   //////////////////////////////
   // saturating counters
   //////////////////////////////

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         cnt_r <= '0;
      end
      else if (clear_i)
      begin
         cnt_r <= '0;  // new window
      end
      else if (active_i)
      begin
         for (int i = 0; i < prof_pkg::num_core_stalls_lp; i++)
         begin
            if (stall_v[i] && (cnt_r[i] != '1))
            begin
               cnt_r[i] <= cnt_r[i] + 1'b1;
            end
         end
      end
   end

   assign dmem_cnt_o    = cnt_r[0];
   assign dx_cnt_o      = cnt_r[1];  // dependency stalls
   assign bt_cnt_o      = cnt_r[2];  // branch flushes
   assign res_acq_cnt_o = cnt_r[3];

endmodule

`default_nettype wire

// ==== rtl/prof_net_stalls.sv ====
`timescale 1ns/1ns
`default_nettype none

module prof_net_stalls
  (
   input  wire                                  clk,
   input  wire                                  rst_n_i,
   input  wire                                  clear_i,
   input  wire                                  active_i,
   input  wire                                  in_ready_i,
   input  wire                                  out_ready_i,
   input  wire [prof_pkg::credit_width_lp-1:0]  out_credits_i,
   output logic [prof_pkg::cnt_width_lp-1:0]    in_fifo_cnt_o,
   output logic [prof_pkg::cnt_width_lp-1:0]    out_fifo_cnt_o,
   output logic [prof_pkg::cnt_width_lp-1:0]    credit_cnt_o
   );

   logic                                                                 in_full;
   logic                                                                 out_full;
   logic                                                                 no_credit;
   logic [prof_pkg::num_net_stalls_lp-1:0]                               stall_v;
   logic [prof_pkg::num_net_stalls_lp-1:0][prof_pkg::cnt_width_lp-1:0]   cnt_r;

   //////////////////////////////
   // endpoint status to events
   //////////////////////////////

   assign in_full   = ~in_ready_i;    // input fifo not taking flits
   assign out_full  = ~out_ready_i;
   assign no_credit = (out_credits_i == '0);  // all requests outstanding

   assign stall_v = {no_credit, out_full, in_full};

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         cnt_r <= '0;
      end
      else if (clear_i)
      begin
         cnt_r <= '0;
      end
      else if (active_i)
      begin
         for (int i = 0; i < prof_pkg::num_net_stalls_lp; i++)
         begin
            if (stall_v[i] && (cnt_r[i] != '1))  // saturate
            begin
               cnt_r[i] <= cnt_r[i] + 1'b1;
            end
         end
      end
   end

   assign in_fifo_cnt_o  = cnt_r[0];
   assign out_fifo_cnt_o = cnt_r[1];
   assign credit_cnt_o   = cnt_r[2];

endmodule

`default_nettype wire

// ==== rtl/prof_pkg.sv ====
`default_nettype none

package prof_pkg;

   //////////////////////////////
   // sizes
   //////////////////////////////

   localparam int cnt_width_lp      = 32;  // every counter
   localparam int coord_width_lp    = 6;   // tile x and y
   localparam int win_cnt_width_lp  = 18; // completed windows
   localparam int idx_width_lp      = 4;
   localparam int credit_width_lp   = 4;  // endpoint out credits

   localparam int num_core_stalls_lp = 4; // dmem, dx, bt, res_acq
   localparam int num_net_stalls_lp  = 3; // in fifo, out fifo, credit

   //////////////////////////////
   // read indices
   //////////////////////////////

   localparam logic [idx_width_lp-1:0] idx_status_lp   = 4'd0;
   localparam logic [idx_width_lp-1:0] idx_cycles_lp   = 4'd1;
   localparam logic [idx_width_lp-1:0] idx_dmem_lp     = 4'd2;
   localparam logic [idx_width_lp-1:0] idx_dx_lp       = 4'd3;
   localparam logic [idx_width_lp-1:0] idx_bt_lp       = 4'd4;
   localparam logic [idx_width_lp-1:0] idx_res_acq_lp  = 4'd5;
   localparam logic [idx_width_lp-1:0] idx_in_fifo_lp  = 4'd6;
   localparam logic [idx_width_lp-1:0] idx_out_fifo_lp = 4'd7;
   localparam logic [idx_width_lp-1:0] idx_credit_lp   = 4'd8;
   // 9..15 read as zero

   //////////////////////////////
   // read word
   //////////////////////////////

   // status word, msb first
   typedef struct packed {
      logic [coord_width_lp-1:0]   tile_y;
      logic [coord_width_lp-1:0]   tile_x;
      logic                        active;     // window open
      logic                        done;       // last window finished
      logic [win_cnt_width_lp-1:0] win_count;
   } prof_status_s;

   // one 32 bit word, seen as a count or as the status
   typedef union packed {
      logic [cnt_width_lp-1:0] raw;     // counter indices
      prof_status_s            status;  // index 0
   } prof_rd_word_u;

endpackage

`default_nettype wire

// ==== rtl/prof_readout.sv ====
`timescale 1ns/1ns
`default_nettype none

module prof_readout
  (
   input  wire                                     clk,
   input  wire                                     rst_n_i,
   input  wire                                     rd_en_i,
   input  wire [prof_pkg::idx_width_lp-1:0]        rd_idx_i,
   input  wire [prof_pkg::coord_width_lp-1:0]      tile_x_i,
   input  wire [prof_pkg::coord_width_lp-1:0]      tile_y_i,
   input  wire                                     active_i,
   input  wire                                     done_i,
   input  wire [prof_pkg::win_cnt_width_lp-1:0]    win_count_i,
   input  wire [prof_pkg::cnt_width_lp-1:0]        cycle_cnt_i,
   input  wire [prof_pkg::cnt_width_lp-1:0]        dmem_cnt_i,
   input  wire [prof_pkg::cnt_width_lp-1:0]        dx_cnt_i,
   input  wire [prof_pkg::cnt_width_lp-1:0]        bt_cnt_i,
   input  wire [prof_pkg::cnt_width_lp-1:0]        res_acq_cnt_i,
   input  wire [prof_pkg::cnt_width_lp-1:0]        in_fifo_cnt_i,
   input  wire [prof_pkg::cnt_width_lp-1:0]        out_fifo_cnt_i,
   input  wire [prof_pkg::cnt_width_lp-1:0]        credit_cnt_i,
   output logic [prof_pkg::cnt_width_lp-1:0]       rd_data_o,
   output logic                                    rd_valid_o
   );

   logic                               rd_en_r;
   logic [prof_pkg::idx_width_lp-1:0]  rd_idx_r;
   prof_pkg::prof_rd_word_u            rd_word;

   //////////////////////////////
   // request stage
   //////////////////////////////

   // counters settle at the request edge, so the select waits one cycle
   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         rd_en_r <= 1'b0;
      end
      else
      begin
         rd_en_r <= rd_en_i;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rd_en_i)
      begin
         rd_idx_r <= rd_idx_i;
      end
   end

   // word select
   always_comb
   begin
      rd_word.raw = '0;
      case (rd_idx_r)
         prof_pkg::idx_status_lp:
         begin
            rd_word.status.tile_y    = tile_y_i;
            rd_word.status.tile_x    = tile_x_i;
            rd_word.status.active    = active_i;
            rd_word.status.done      = done_i;
            rd_word.status.win_count = win_count_i;
         end
         prof_pkg::idx_cycles_lp:   rd_word.raw = cycle_cnt_i;
         prof_pkg::idx_dmem_lp:     rd_word.raw = dmem_cnt_i;
         prof_pkg::idx_dx_lp:       rd_word.raw = dx_cnt_i;
         prof_pkg::idx_bt_lp:       rd_word.raw = bt_cnt_i;
         prof_pkg::idx_res_acq_lp:  rd_word.raw = res_acq_cnt_i;
         prof_pkg::idx_in_fifo_lp:  rd_word.raw = in_fifo_cnt_i;
         prof_pkg::idx_out_fifo_lp: rd_word.raw = out_fifo_cnt_i;
         prof_pkg::idx_credit_lp:   rd_word.raw = credit_cnt_i;
         default:                   rd_word.raw = '0;  // unused indices
      endcase
   end

   //////////////////////////////
   // response stage
   //////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rd_en_r)
      begin
         rd_data_o <= rd_word.raw;
      end
   end

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         rd_valid_o <= 1'b0;
      end
      else
      begin
         rd_valid_o <= rd_en_r;  // one cycle per request
      end
   end

endmodule

`default_nettype wire

// ==== rtl/prof_window.sv ====
`timescale 1ns/1ns
`default_nettype none

module prof_window
  (
   input  wire                                     clk,
   input  wire                                     rst_n_i,
   input  wire                                     freeze_i,
   input  wire                                     finish_i,
   output logic                                    clear_o,
   output logic                                    active_o,
   output logic                                    done_o,
   output logic [prof_pkg::cnt_width_lp-1:0]       cycle_cnt_o,
   output logic [prof_pkg::win_cnt_width_lp-1:0]   win_count_o
   );

   logic freeze_r;   // freeze level at previous edge
   logic unfreeze;
   logic finish;

   // tile leaves freeze at this edge
   assign unfreeze = freeze_r & ~freeze_i;
   assign finish   = active_o & finish_i;  // ignored outside a window

   assign clear_o = unfreeze;

   //////////////////////////////
   // window state
   //////////////////////////////

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         freeze_r    <= 1'b1;  // tile comes out of reset frozen
         active_o    <= 1'b0;
         done_o      <= 1'b0;
         win_count_o <= '0;
      end
      else
      begin
         freeze_r <= freeze_i;
         if (unfreeze)
         begin
            // a new window, wins over a finish at the same edge
            active_o <= 1'b1;
            done_o   <= 1'b0;
         end
         else if (finish)
         begin
            active_o <= 1'b0;
            done_o   <= 1'b1;
            if (win_count_o != '1)
            begin
               win_count_o <= win_count_o + 1'b1;
            end
         end
      end
   end

   // active cycles, finish edge included
   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         cycle_cnt_o <= '0;
      end
      else if (unfreeze)
      begin
         cycle_cnt_o <= '0;
      end
      else if (active_o && (cycle_cnt_o != '1))
      begin
         cycle_cnt_o <= cycle_cnt_o + 1'b1;  // sticks at all ones
      end
   end

endmodule

`default_nettype wire

// ==== rtl/tile_profiler.sv ====
`timescale 1ns/1ns
`default_nettype none

module tile_profiler
  (
   input  wire                                  clk,
   input  wire                                  rst_n_i,
   input  wire [prof_pkg::coord_width_lp-1:0]   tile_x_i,
   input  wire [prof_pkg::coord_width_lp-1:0]   tile_y_i,
   input  wire                                  freeze_i,
   input  wire                                  finish_i,
   input  wire                                  dmem_stall_i,
   input  wire                                  dx_stall_i,
   input  wire                                  bt_stall_i,
   input  wire                                  res_acq_stall_i,
   input  wire                                  in_ready_i,
   input  wire                                  out_ready_i,
   input  wire [prof_pkg::credit_width_lp-1:0]  out_credits_i,
   input  wire                                  rd_en_i,
   input  wire [prof_pkg::idx_width_lp-1:0]     rd_idx_i,
   output logic [prof_pkg::cnt_width_lp-1:0]    rd_data_o,
   output logic                                 rd_valid_o
   );

   logic                                    prof_clear;
   logic                                    prof_active;
   logic                                    done;
   logic [prof_pkg::cnt_width_lp-1:0]       cycle_cnt;
   logic [prof_pkg::win_cnt_width_lp-1:0]   win_count;
   logic [prof_pkg::cnt_width_lp-1:0]       dmem_cnt;
   logic [prof_pkg::cnt_width_lp-1:0]       dx_cnt;
   logic [prof_pkg::cnt_width_lp-1:0]       bt_cnt;
   logic [prof_pkg::cnt_width_lp-1:0]       res_acq_cnt;
   logic [prof_pkg::cnt_width_lp-1:0]       in_fifo_cnt;
   logic [prof_pkg::cnt_width_lp-1:0]       out_fifo_cnt;
   logic [prof_pkg::cnt_width_lp-1:0]       credit_cnt;

   //////////////////////////////
   // window control
   //////////////////////////////

   prof_window window
     (.clk         (clk)
      ,.rst_n_i     (rst_n_i)
      ,.freeze_i    (freeze_i)
      ,.finish_i    (finish_i)
      ,.clear_o     (prof_clear)
      ,.active_o    (prof_active)
      ,.done_o      (done)
      ,.cycle_cnt_o (cycle_cnt)
      ,.win_count_o (win_count)
      );

   //////////////////////////////
   // stall counters
   //////////////////////////////

   prof_core_stalls core_stalls
     (.clk              (clk)
      ,.rst_n_i          (rst_n_i)
      ,.clear_i          (prof_clear)
      ,.active_i         (prof_active)
      ,.dmem_stall_i     (dmem_stall_i)
      ,.dx_stall_i       (dx_stall_i)
      ,.bt_stall_i       (bt_stall_i)
      ,.res_acq_stall_i  (res_acq_stall_i)
      ,.dmem_cnt_o       (dmem_cnt)
      ,.dx_cnt_o         (dx_cnt)
      ,.bt_cnt_o         (bt_cnt)
      ,.res_acq_cnt_o    (res_acq_cnt)
      );

   prof_net_stalls net_stalls
     (.clk             (clk)
      ,.rst_n_i         (rst_n_i)
      ,.clear_i         (prof_clear)
      ,.active_i        (prof_active)
      ,.in_ready_i      (in_ready_i)
      ,.out_ready_i     (out_ready_i)
      ,.out_credits_i   (out_credits_i)
      ,.in_fifo_cnt_o   (in_fifo_cnt)
      ,.out_fifo_cnt_o  (out_fifo_cnt)
      ,.credit_cnt_o    (credit_cnt)
      );

   // host read port
   prof_readout readout
     (.clk             (clk)
      ,.rst_n_i         (rst_n_i)
      ,.rd_en_i         (rd_en_i)
      ,.rd_idx_i        (rd_idx_i)
      ,.tile_x_i        (tile_x_i)
      ,.tile_y_i        (tile_y_i)
      ,.active_i        (prof_active)
      ,.done_i          (done)
      ,.win_count_i     (win_count)
      ,.cycle_cnt_i     (cycle_cnt)
      ,.dmem_cnt_i      (dmem_cnt)
      ,.dx_cnt_i        (dx_cnt)
      ,.bt_cnt_i        (bt_cnt)
      ,.res_acq_cnt_i   (res_acq_cnt)
      ,.in_fifo_cnt_i   (in_fifo_cnt)
      ,.out_fifo_cnt_i  (out_fifo_cnt)
      ,.credit_cnt_i    (credit_cnt)
      ,.rd_data_o       (rd_data_o)
      ,.rd_valid_o      (rd_valid_o)
      );

endmodule

`default_nettype wire

// ==== src.f ====
rtl/prof_pkg.sv
rtl/prof_window.sv
rtl/prof_core_stalls.sv
rtl/prof_net_stalls.sv
rtl/prof_readout.sv
rtl/tile_profiler.sv
dv/tb_clk_gen.sv
dv/tile_profiler_properties.sv
dv/tb_tile_profiler.sv
